// ==== vlog.f ====
logic/note_pkg.sv
logic/player_pkg.sv
logic/key_decoder.sv
logic/song_rom.sv
logic/song_sequencer.sv
logic/tone_arbiter.sv
logic/tone_generator.sv
logic/learning_top.sv
test/learning_tb.sv

// ==== Makefile ====
# Verilator build and run for the note player testbench

SOURCES := $(wildcard logic/*.sv test/*.sv)

obj_dir/Vlearning_tb: vlog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module learning_tb -f vlog.f

run: obj_dir/Vlearning_tb
	obj_dir/Vlearning_tb | tee sim.log
	! grep -q "SOME TESTS FAILED" sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== test/learning_tb.sv ====
// Note player testbench
`default_nettype none

module learning_tb
	import note_pkg::*;
	import player_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		keys_t   keys;
		octave_t octave;
		mode_t   mode;
		note_t   note;  // 0 means the speaker stays low
	} free_row_t;

	typedef struct packed {
		song_sel_t  song;
		led_t [0:7] leds;  // Steps 1..8
		logic [0:7] half;
	} song_row_t;

	// Octave code 1 is octave 3, 0 is octave 4, 2 is octave 5
	localparam free_row_t free_tab [0:27] = '{
		'{8'h01, oct_3, mode_free, 5'd1},  '{8'h02, oct_3, mode_free, 5'd2},
		'{8'h04, oct_3, mode_free, 5'd3},  '{8'h08, oct_3, mode_free, 5'd4},
		'{8'h10, oct_3, mode_free, 5'd5},  '{8'h20, oct_3, mode_free, 5'd6},
		'{8'h40, oct_3, mode_free, 5'd7},  '{8'h01, oct_4, mode_free, 5'd8},
		'{8'h02, oct_4, mode_free, 5'd9},  '{8'h04, oct_4, mode_free, 5'd10},
		'{8'h08, oct_4, mode_free, 5'd11}, '{8'h10, oct_4, mode_free, 5'd12},
		'{8'h20, oct_4, mode_free, 5'd13}, '{8'h40, oct_4, mode_free, 5'd14},
		'{8'h01, oct_5, mode_free, 5'd15}, '{8'h02, oct_5, mode_free, 5'd16},
		'{8'h04, oct_5, mode_free, 5'd17}, '{8'h08, oct_5, mode_free, 5'd18},
		'{8'h10, oct_5, mode_free, 5'd19}, '{8'h20, oct_5, mode_free, 5'd20},
		'{8'h40, oct_5, mode_free, 5'd21}, '{8'h04, 2'd3, mode_free, 5'd0},
		'{8'h00, oct_4, mode_free, 5'd0},  '{8'h05, oct_4, mode_free, 5'd0},
		'{8'h80, oct_4, mode_free, 5'd0},  '{8'h81, oct_3, mode_free, 5'd0},
		'{8'h10, oct_4, 3'd0, 5'd0},       '{8'h10, oct_5, 3'd3, 5'd0}
	};

	// LED is the key of the note, one-hot on (note - 1) mod 7, off for a rest
	localparam song_row_t song_tab [0:1] = '{
		'{song_twinkle, {8'h01, 8'h01, 8'h10, 8'h10, 8'h20, 8'h20, 8'h10, 8'h00}, 8'b0},
		'{song_ode, {8'h04, 8'h04, 8'h08, 8'h10, 8'h10, 8'h08, 8'h04, 8'h02}, 8'b0}
	};

	// Every bar of eight twinkle steps shows five LED runs, and bars end on a rest
	localparam int twinkle_runs = 30;
	localparam int twinkle_steps = 48;

	logic      clk;
	logic      reset;
	keys_t     keys;
	octave_t   octave;
	mode_t     mode;
	song_sel_t song;
	logic      speaker;
	led_t      led;

	int checks;
	int errors;
	int timeouts;

	learning_top dut_i (
		.clk(clk), .reset(reset), .keys(keys), .octave(octave), .mode(mode), .song(song),
		.speaker(speaker), .led(led)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic apply_inputs(input keys_t k, input octave_t o, input mode_t m,
		input song_sel_t s);
		@(posedge clk);
		#1;
		keys = k;
		octave = o;
		mode = m;
		song = s;
	endtask

	task automatic skip_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(negedge clk);
	endtask

	task automatic wait_speaker_edge(input int limit, output int cycles);
		logic start;
		start = speaker;
		cycles = 0;
		while (speaker === start && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (speaker === start) begin
			timeouts++;
			$display("Timeout: speaker did not toggle within %0d cycles at %0t", limit, $time);
		end
	endtask

	task automatic wait_led_change(input int limit, output int cycles);
		led_t start;
		start = led;
		cycles = 0;
		while (led === start && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (led === start) begin
			timeouts++;
			$display("Timeout: LED stayed at 0x%0h for %0d cycles at %0t", start, limit, $time);
		end
	endtask

	task automatic expect_quiet(input int n, input string what);
		int high;
		int lit;
		high = 0;
		lit = 0;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			if (speaker !== 1'b0)
				high++;
			if (led !== 8'h00)
				lit++;
		end
		check_value({what, " speaker high cycles"}, high, 0);
		check_value({what, " led lit cycles"}, lit, 0);
	endtask

	task automatic walk_song_slots(input int s);
		int len;
		int snd;
		int cycles;
		int high;
		apply_inputs(8'h00, oct_4, 3'd0, song_tab[s].song);
		skip_cycles(5);
		apply_inputs(8'h00, oct_4, mode_song, song_tab[s].song);
		wait_led_change(20, cycles);  // Start of step 1
		for (int i = 0; i < 8; i++) begin
			len = song_tab[s].half[i] ? beat_cycles / 2 : beat_cycles;
			snd = len * gap_num / gap_den;
			high = 0;
			for (int off = 0; off < len; off++) begin
				if (off > 0)
					@(negedge clk);
				if (off == len / 2)
					check_value("led mid slot", led, song_tab[s].leds[i]);
				if (off >= snd + 4 && off < len - 1 && speaker !== 1'b0)
					high++;  // Request to speaker is two stages
			end
			check_value("speaker high in slot gap", high, 0);
			if (i < 7) begin
				if (song_tab[s].leds[i + 1] != song_tab[s].leds[i])
					wait_led_change(4, cycles);
				else
					@(negedge clk);  // Same LED, boundary by count
			end
		end
	endtask

	initial begin
		int cycles;
		int total;
		int a;
		int b;
		keys_t rkeys;
		clk = 1'b0;
		reset = 1'b1;
		keys = 8'h00;
		octave = oct_4;
		mode = 3'd0;
		song = song_twinkle;
		checks = 0;
		errors = 0;
		timeouts = 0;
		void'($urandom(32'h820293bd));
		for (int i = 0; i < 10; i++)
			@(posedge clk);
		#1;
		reset = 1'b0;

		expect_quiet(20, "after reset");

		for (int r = 0; r < 28; r++) begin
			apply_inputs(8'h00, oct_4, mode_free, song_twinkle);
			skip_cycles(5);
			apply_inputs(free_tab[r].keys, free_tab[r].octave, free_tab[r].mode, song_twinkle);
			if (free_tab[r].note == note_rest) begin
				expect_quiet(100, "invalid key word");
			end else begin
				wait_speaker_edge(20, cycles);  // First rise
				wait_speaker_edge(64, cycles);
				check_value("speaker half period", cycles, 44 - int'(free_tab[r].note));
			end
		end

		// At least two of the seven keys held
		for (int n = 0; n < 8; n++) begin
			a = $urandom % 7;
			b = (a + 1 + $urandom % 6) % 7;
			rkeys = keys_t'($urandom) | keys_t'(1 << a) | keys_t'(1 << b);
			apply_inputs(rkeys, octave_t'($urandom % 3), mode_free, song_twinkle);
			expect_quiet(100, "random multi-key");
		end

		walk_song_slots(0);
		walk_song_slots(1);

		apply_inputs(8'h00, oct_4, 3'd0, song_twinkle);
		skip_cycles(5);
		apply_inputs(8'h00, oct_4, mode_song, song_twinkle);
		wait_led_change(20, cycles);
		skip_cycles(900);
		check_value("led in twinkle step 3", led, song_tab[0].leds[2]);
		apply_inputs(8'h00, oct_4, mode_song, song_ode);
		wait_led_change(10, cycles);
		skip_cycles(300);
		check_value("led after song change", led, song_tab[1].leds[0]);
		wait_led_change(1000, cycles);  // Ode steps 1 and 2 share an LED
		check_value("led in ode step 3", led, song_tab[1].leds[2]);
		apply_inputs(8'h00, oct_4, 3'd0, song_ode);
		skip_cycles(10);
		check_value("led in idle mode", led, 8'h00);
		apply_inputs(8'h00, oct_4, mode_song, song_ode);
		wait_led_change(20, cycles);
		check_value("led on song re-entry", led, song_tab[1].leds[0]);
		skip_cycles(900);
		check_value("led after song re-entry", led, song_tab[1].leds[2]);

		// Full twinkle run and wrap
		apply_inputs(8'h00, oct_4, 3'd0, song_twinkle);
		skip_cycles(5);
		apply_inputs(8'h00, oct_4, mode_song, song_twinkle);
		wait_led_change(20, cycles);
		total = 0;
		for (int n = 0; n < twinkle_runs; n++) begin
			wait_led_change(2 * beat_cycles + 10, cycles);
			total += cycles;
		end
		check_value("led after twinkle wrap", led, song_tab[0].leds[0]);
		check_value("cycles through twinkle", total, twinkle_steps * beat_cycles);

		$display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/learning_top.sv ====
// Note player top level
`default_nettype none

module learning_top
	import note_pkg::*;
	import player_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire keys_t     keys,
	input  wire octave_t   octave,
	input  wire mode_t     mode,
	input  wire song_sel_t song,
	output wire            speaker,
	output wire led_t      led
);

	tone_req_t key_req;
	tone_req_t song_req;
	tone_req_t grant_req;
	step_t     step;
	step_idx_t length;
	step_idx_t idx;
	logic      play_en;

	key_decoder key_decoder_i (
		.clk(clk), .reset(reset), .keys(keys), .octave(octave), .req(key_req)
	);

	song_rom song_rom_i (
		.song(song), .idx(idx), .step(step), .length(length)
	);

	song_sequencer song_sequencer_i (
		.clk(clk), .reset(reset), .play_en(play_en), .song(song), .step(step),
		.length(length), .idx(idx), .req(song_req), .led(led)
	);

	tone_arbiter tone_arbiter_i (
		.clk(clk), .reset(reset), .mode(mode), .key_req(key_req), .song_req(song_req),
		.play_en(play_en), .grant_req(grant_req)
	);

	tone_generator tone_generator_i (
		.clk(clk), .reset(reset), .req(grant_req), .speaker(speaker)
	);

endmodule

`default_nettype wire

// ==== logic/tone_generator.sv ====
// Square wave tone generator
`default_nettype none

module tone_generator
	import note_pkg::*;
	import player_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire tone_req_t req,
	output logic           speaker
);

	note_t        cur_note;
	half_period_t cnt;
	half_period_t half_last;

	assign half_last = tone_half_period[req.note] - 6'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			speaker <= 1'b0;
			cnt <= '0;
			cur_note <= note_rest;
		end else if (!req.valid) begin
			speaker <= 1'b0;  // Silent
			cnt <= '0;
			cur_note <= note_rest;
		end else if (req.note != cur_note) begin
			cur_note <= req.note;
			cnt <= half_last;  // First rise on the next cycle
			speaker <= 1'b0;
		end else if (cnt == half_last) begin
			cnt <= '0;
			speaker <= ~speaker;
		end else begin
			cnt <= cnt + 6'd1;
		end
	end

	// Neither source may request a rest as a valid note
	a_no_rest_note: assert property (@(posedge clk) disable iff (reset)
		req.valid |-> req.note != note_rest)
		else $error("valid tone request with note 0");

endmodule

`default_nettype wire

// ==== logic/tone_arbiter.sv ====
// Tone source arbiter
`default_nettype none

module tone_arbiter
	import player_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire mode_t     mode,
	input  wire tone_req_t key_req,
	input  wire tone_req_t song_req,
	output logic           play_en,
	output tone_req_t      grant_req
);

	tone_req_t sel_req;

	always_comb begin
		case (mode)
			mode_free: sel_req = key_req;
			mode_song: sel_req = song_req;
			default:   sel_req = '0;  // Idle
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			play_en <= 1'b0;
			grant_req <= '0;
		end else begin
			play_en <= mode == mode_song;
			grant_req <= sel_req;
		end
	end

	// Idle mode silences the generator on the next cycle
	a_idle_silent: assert property (@(posedge clk) disable iff (reset)
		mode != mode_free && mode != mode_song |=> !grant_req.valid)
		else $error("tone granted after idle mode");

endmodule

`default_nettype wire

// ==== logic/song_sequencer.sv ====
// Song step sequencer
`default_nettype none

module song_sequencer
	import note_pkg::*;
	import player_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire            play_en,
	input  wire song_sel_t song,
	input  wire step_t     step,
	input  wire step_idx_t length,
	output step_idx_t      idx,
	output tone_req_t      req,
	output led_t           led
);

	slot_cnt_t slot_cnt;
	slot_cnt_t slot_last;
	slot_cnt_t sound_len;
	song_sel_t last_song;
	logic      restart;
	logic      slot_end;

	always_comb begin
		restart = !play_en || song != last_song;  // Back to step 1
		slot_last = step.half ? half_slot_last : full_slot_last;
		sound_len = step.half ? half_sound : full_sound;
		slot_end = slot_cnt == slot_last;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_cnt <= '0;
			idx <= step_first;
			last_song <= song_twinkle;
			req <= '0;
			led <= '0;
		end else begin
			last_song <= song;
			led <= play_en ? step.led : '0;
			req.valid <= !restart && step.note != note_rest && slot_cnt < sound_len;
			req.note <= step.note;
			if (restart) begin
				slot_cnt <= '0;
				idx <= step_first;
			end else if (slot_end) begin
				slot_cnt <= '0;
				idx <= (idx >= length) ? step_first : idx + 6'd1;  // Wrap after last step
			end else begin
				slot_cnt <= slot_cnt + 9'd1;
			end
		end
	end

	// Index stays inside the song the ROM reports
	a_idx_in_song: assert property (@(posedge clk) disable iff (reset)
		play_en && song == last_song && length != '0 |-> idx <= length)
		else $error("step index %0d beyond song length %0d", idx, length);

endmodule

`default_nettype wire

// ==== logic/song_rom.sv ====
// Melody tables
`default_nettype none

module song_rom
	import note_pkg::*;
	import player_pkg::*;
(
	input  wire song_sel_t song,
	input  wire step_idx_t idx,
	output step_t          step,
	output step_idx_t      length
);

	note_t twinkle_notes [1:48];
	note_t ode_notes [1:62];

	// Steps are numbered from 1, one row per bar or so
	assign twinkle_notes = '{
		8,  8,  12, 12, 13, 13, 12, 0,
		11, 11, 10, 10, 9,  9,  8,  0,
		12, 12, 11, 11, 10, 10, 9,  0,
		12, 12, 11, 11, 10, 10, 9,  0,
		8,  8,  12, 12, 13, 13, 12, 0,
		11, 11, 10, 10, 9,  9,  8,  0
	};

	assign ode_notes = '{
		10, 10, 11, 12, 12, 11, 10, 9,
		8,  8,  9,  10, 10, 9,  9,  10,
		10, 11, 12, 12, 11, 10, 9,  8,
		8,  9,  10, 9,  8,  8,  9,  9,
		10, 8,  9,  10, 11, 10, 8,  9,
		10, 11, 10, 9,  8,  9,  5,  10,
		10, 11, 12, 12, 11, 10, 9,  8,
		8,  9,  10, 9,  8,  8
	};

	// LED lights the key of the note, all off for a rest
	function automatic led_t key_led(note_t n);
		led_t l;
		l = '0;
		if (n != note_rest)
			l[(n - 5'd1) % notes_per_octave] = 1'b1;
		return l;
	endfunction

	always_comb begin
		step = '0;
		length = '0;
		case (song)
			song_twinkle: begin
				length = step_idx_t'($size(twinkle_notes));
				if (idx >= step_first && idx <= length)
					step.note = twinkle_notes[idx];
			end
			song_ode: begin
				length = step_idx_t'($size(ode_notes));
				if (idx >= step_first && idx <= length) begin
					step.note = ode_notes[idx];
					step.half = idx inside {6'd14, 6'd29, 6'd36, 6'd37, 6'd41, 6'd42, 6'd61};
				end
			end
			default: ;  // Silent song, length 0
		endcase
		step.led = key_led(step.note);
	end

endmodule

`default_nettype wire

// ==== logic/key_decoder.sv ====
// Keyboard note decoder
`default_nettype none

module key_decoder
	import note_pkg::*;
	import player_pkg::*;
(
	input  wire          clk,
	input  wire          reset,
	input  wire keys_t   keys,
	input  wire octave_t octave,
	output tone_req_t    req
);

	logic       keys_ok;
	logic       octave_ok;
	logic [2:0] key_pos;
	note_t      base;

	always_comb begin
		// Exactly one of the seven keys
		keys_ok = (keys & ~key_mask) == '0 && keys != '0 && (keys & (keys - 8'd1)) == '0;
		key_pos = '0;
		for (int i = 0; i < notes_per_octave; i++) begin
			if (keys[i])
				key_pos = 3'(i);
		end
		octave_ok = 1'b1;
		case (octave)
			oct_3: base = '0;
			oct_4: base = note_t'(notes_per_octave);
			oct_5: base = note_t'(2 * notes_per_octave);
			default: begin
				base = '0;
				octave_ok = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			req <= '0;
		end else begin
			req.valid <= keys_ok && octave_ok;
			req.note <= (keys_ok && octave_ok) ? base + note_t'(key_pos) + 5'd1 : note_rest;
		end
	end

endmodule

`default_nettype wire

// ==== logic/player_pkg.sv ====
// Playback definitions
`default_nettype none

package player_pkg;

	import note_pkg::*;

	typedef logic [2:0] mode_t;
	typedef logic [1:0] song_sel_t;
	typedef logic [5:0] step_idx_t;
	typedef logic [7:0] led_t;
	typedef logic [8:0] slot_cnt_t;

	localparam mode_t mode_free = 3'd1;  // Anything else but song is idle
	localparam mode_t mode_song = 3'd5;

	localparam song_sel_t song_twinkle = 2'd0;
	localparam song_sel_t song_ode = 2'd1;

	localparam step_idx_t step_first = 6'd1;

	typedef struct packed {
		note_t note;
		led_t  led;
		logic  half;  // Half-beat slot
	} step_t;

	typedef struct packed {
		logic  valid;
		note_t note;
	} tone_req_t;

	// Slot timing, the note sounds for gap_num/gap_den of its slot
	localparam int beat_cycles = 400;
	localparam int gap_num = 9;
	localparam int gap_den = 10;

	localparam slot_cnt_t full_slot_last = slot_cnt_t'(beat_cycles - 1);
	localparam slot_cnt_t half_slot_last = slot_cnt_t'(beat_cycles / 2 - 1);
	localparam slot_cnt_t full_sound = slot_cnt_t'(beat_cycles * gap_num / gap_den);
	localparam slot_cnt_t half_sound = slot_cnt_t'(beat_cycles / 2 * gap_num / gap_den);

endpackage

`default_nettype wire

// ==== logic/note_pkg.sv ====
// Pitch definitions
`default_nettype none

package note_pkg;

	typedef logic [4:0] note_t;        // 0 is silence, 1..21 are C3..B5
	typedef logic [7:0] keys_t;        // One-hot keys, bit 0 is C
	typedef logic [1:0] octave_t;
	typedef logic [5:0] half_period_t;

	localparam note_t note_rest = 5'd0;
	localparam int notes_per_octave = 7;

	// Bits 0..6 carry C..B, bit 7 has no key
	localparam keys_t key_mask = 8'h7f;

	// Octave select codes, 3 is not a valid setting
	localparam octave_t oct_4 = 2'd0;
	localparam octave_t oct_3 = 2'd1;
	localparam octave_t oct_5 = 2'd2;

	// Half period in clock cycles, 44 minus the note code
	localparam half_period_t tone_half_period [0:21] = '{
		6'd0,                                             // Silence
		6'd43, 6'd42, 6'd41, 6'd40, 6'd39, 6'd38, 6'd37,  // Octave 3
		6'd36, 6'd35, 6'd34, 6'd33, 6'd32, 6'd31, 6'd30,  // Octave 4
		6'd29, 6'd28, 6'd27, 6'd26, 6'd25, 6'd24, 6'd23   // Octave 5
	};

endpackage

`default_nettype wire
